// File: cpu_glue_chk.sv
//----------------------------------------
// Bound assertions on interrupt, NMI
// and video chip-select rules
//----------------------------------------
`timescale 1ns/10ps

module cpu_glue_chk import cpu_glue_pkg::*; (
    input logic       clk,
    input logic       RESETn,
    input cpu_bus_t   main_bus,
    input cpu_bus_t   sub_bus,
    input io_strobe_t io_sel,
    input logic       mbox_sel_n,
    input logic       main_int_n,
    input logic       sub_int_n,
    input logic       main_nmi_n,
    input logic       sub_nmi_n,
    input video_cs_t  vcs
);

    logic main_mrd;                             // Main CPU reading C700
    logic sub_mrd;                              // Sub CPU reading C000

    assign main_mrd = !io_sel.mailbox && !main_bus.rd_n;
    assign sub_mrd  = !mbox_sel_n && !sub_bus.rd_n;

    // NMI falls only two samples after the other side's mailbox read
    a_sub_nmi: assert property (@(posedge clk) disable iff (!RESETn)
        $fell(sub_nmi_n) |-> $past(main_mrd, 2)) else $error("sub NMI without mailbox read");
    a_main_nmi: assert property (@(posedge clk) disable iff (!RESETn)
        $fell(main_nmi_n) |-> $past(sub_mrd, 2)) else $error("main NMI without mailbox read");

    // Interrupt held until an I/O cycle
    a_main_int: assert property (@(posedge clk) disable iff (!RESETn)
        !main_int_n && main_bus.iorq_n |=> !main_int_n) else $error("main INT lost");
    a_sub_int: assert property (@(posedge clk) disable iff (!RESETn)
        !sub_int_n && sub_bus.iorq_n |=> !sub_int_n) else $error("sub INT lost");

    a_vcs_onehot: assert property (@(posedge clk) disable iff (!RESETn)
        $onehot0({!vcs.front_cs_n, !vcs.side_cs_n, !vcs.back1_cs_n, vcs.disc}))
        else $error("more than one video select active");

endmodule

bind cpu_glue_top cpu_glue_chk u_chk (
    .clk(clk), .RESETn(RESETn), .main_bus(main_bus), .sub_bus(sub_bus),
    .io_sel(io_sel), .mbox_sel_n(mbox_sel_n), .main_int_n(main_int_n),
    .sub_int_n(sub_int_n), .main_nmi_n(main_nmi_n), .sub_nmi_n(sub_nmi_n), .vcs(vcs)
);

// File: cpu_glue_input.txt
# op cpu addr data aux exp, all hex
# op 1 port rd, 2 rd, 3 vbl, 4 io, 5 wr, 6 video rd (aux a_b,vdg_n), 7 v_out, 8 latch
1 0 C000 00 0 00
1 0 C100 00 0 00
1 0 C200 00 0 00
1 0 C500 00 0 00
1 0 C600 00 0 00
1 0 C300 00 0 00
2 0 0123 00 0 FF
2 0 8000 00 0 FF
3 0 0000 00 0 00
4 0 0000 00 0 00
4 1 0000 00 0 00
3 0 0000 00 0 00
4 1 0010 00 0 00
2 0 C700 00 0 FF
5 1 C000 11 0 00
2 1 C000 00 0 FF
5 0 C700 22 0 00
6 0 D123 00 0 00
6 1 E456 00 1 00
6 0 F789 00 1 00
6 1 F0AB 00 1 00
6 0 C9AA 00 0 00
6 1 CB00 00 3 00
6 0 CE00 00 2 00
7 0 0000 5A 0 A5
7 0 0000 5A 1 A5
7 0 0000 5A 3 A5
8 0 0000 3C 0 00
2 0 D010 00 0 3C
8 1 0000 C3 0 00
2 1 E020 00 0 C3

// File: cpu_glue_pkg.sv
//----------------------------------------
// Two-CPU glue logic shared definitions
// Widths, address map constants and bus types
//----------------------------------------
package cpu_glue_pkg;

    localparam int ADDR_W = 16;                   // CPU address bus
    localparam int DATA_W = 8;                    // CPU data bus
    localparam int VA_W   = 12;                   // Shared video address bus

    //----------------------------------------
    // Address map
    // Page 3 (C000-FFFF), bits 13:11 pick the region
    //   000  I/O page on main CPU, mailbox on sub CPU
    //   001  video registers
    //   010/011  front video RAM
    //   100/101  back1 video RAM
    //   110/111  side video RAM
    // Pages 0-2 are ROM, read back as idle data
    //----------------------------------------
    localparam logic [1:0] PAGE_IO        = 2'd3;
    localparam logic [2:0] REGION_IO      = 3'd0;  // I/O page or mailbox
    localparam logic [2:0] REGION_VREG    = 3'd1;  // Video register block
    localparam logic [2:0] PORT_MAILBOX_A = 3'd7;  // Main CPU C700
    localparam logic [2:0] PORT_MAILBOX_B = 3'd0;  // Sub CPU C000

    // Address seen as memory page plus offset
    typedef struct packed {
        logic [1:0]        page;
        logic [ADDR_W-3:0] offset;
    } cpu_mem_view_t;

    // Same address seen as an I/O port select
    typedef struct packed {
        logic [1:0] page;
        logic [2:0] region;                       // Bits 13:11
        logic [2:0] port;                         // Bits 10:8
        logic [7:0] low;
    } cpu_io_view_t;

    typedef union packed {
        cpu_mem_view_t mem;
        cpu_io_view_t  io;
    } cpu_addr_u;

    // One CPU's bus outputs, strobes active low
    typedef struct packed {
        cpu_addr_u         addr;
        logic [DATA_W-1:0] dout;
        logic              mreq_n;
        logic              iorq_n;
        logic              rd_n;
        logic              wr_n;
    } cpu_bus_t;

    typedef struct packed {
        logic up, down, left, right;
        logic armor, shot, missile;
        logic coin, start, service;
    } player_in_t;

    // Main CPU port selects, all active low
    typedef struct packed {
        logic coin, p1, p2, p1_p2;
        logic mcode, dip1, dip2, mailbox;
    } io_strobe_t;

    // Video selects, disc is active high
    typedef struct packed {
        logic front_cs_n, side_cs_n, back1_cs_n;
        logic disc, vrd_n;
    } video_cs_t;

    // Video register write strobes, active low
    typedef struct packed {
        logic msb, fsx, fsy, b1sx;
        logic b1sy, spare, side_bank, back1_bank;
    } video_reg_t;

endpackage

// File: cpu_glue_top.sv
//----------------------------------------
// Two-CPU board glue logic top level
//----------------------------------------
`timescale 1ns/10ps

module cpu_glue_top import cpu_glue_pkg::*; #(
    parameter logic [DATA_W-1:0] IDLE_DATA = 8'hFF    // ROM and unmapped reads
) (
    input  logic              clk,
    input  logic              RESETn,
    input  cpu_bus_t          main_bus,
    input  cpu_bus_t          sub_bus,
    input  player_in_t        player1,
    input  player_in_t        player2,
    input  logic [15:0]       dsw,
    input  logic              snd_busy,
    input  logic              vbl,
    input  logic              a_b,
    input  logic              vdg_n,
    input  logic              wba_n,
    input  logic              wbb_n,
    input  logic              rla,
    input  logic              rlb,
    input  logic [DATA_W-1:0] v_in,
    output logic [DATA_W-1:0] main_din,
    output logic [DATA_W-1:0] sub_din,
    output logic              main_int_n,
    output logic              sub_int_n,
    output logic              main_nmi_n,
    output logic              sub_nmi_n,
    output logic              ae,
    output logic              be,
    output io_strobe_t        io_sel,
    output logic [VA_W-1:0]   va,
    output logic [DATA_W-1:0] v_out,
    output video_cs_t         vcs,
    output video_reg_t        vreg
);

    logic              main_page_n, sub_page_n;
    logic              main_vrd, sub_vrd;
    logic              mbox_sel_n;                    // Sub CPU C000
    logic [DATA_W-1:0] main_vlatch, sub_vlatch;

    main_cpu_decode #(.IDLE_DATA(IDLE_DATA)) u_main_dec (
        .clk(clk), .RESETn(RESETn), .bus(main_bus),
        .player1(player1), .player2(player2), .dsw(dsw), .snd_busy(snd_busy),
        .vlatch(main_vlatch), .io_sel(io_sel), .page_n(main_page_n),
        .vrd(main_vrd), .ae(ae), .din(main_din)
    );

    sub_cpu_decode #(.IDLE_DATA(IDLE_DATA)) u_sub_dec (
        .clk(clk), .RESETn(RESETn), .bus(sub_bus), .vlatch(sub_vlatch),
        .mbox_sel_n(mbox_sel_n), .page_n(sub_page_n), .vrd(sub_vrd),
        .be(be), .din(sub_din)
    );

    cpu_irq_ctrl u_irq (
        .clk(clk), .RESETn(RESETn), .main_bus(main_bus), .sub_bus(sub_bus),
        .vbl(vbl), .mbox_main_n(io_sel.mailbox), .mbox_sub_n(mbox_sel_n),
        .main_int_n(main_int_n), .sub_int_n(sub_int_n),
        .main_nmi_n(main_nmi_n), .sub_nmi_n(sub_nmi_n)
    );

    video_bus_ctrl u_vbus (
        .clk(clk), .RESETn(RESETn), .main_bus(main_bus), .sub_bus(sub_bus),
        .a_b(a_b), .main_page_n(main_page_n), .sub_page_n(sub_page_n),
        .main_vrd(main_vrd), .sub_vrd(sub_vrd), .vdg_n(vdg_n),
        .wba_n(wba_n), .wbb_n(wbb_n), .rla(rla), .rlb(rlb), .v_in(v_in),
        .va(va), .vcs(vcs), .vreg(vreg), .v_out(v_out),
        .main_vlatch(main_vlatch), .sub_vlatch(sub_vlatch)
    );

endmodule

// File: cpu_irq_ctrl.sv
//----------------------------------------
// Vertical blank interrupts and the
// two-way NMI mailbox between the CPUs
//----------------------------------------
`timescale 1ns/10ps

module cpu_irq_ctrl import cpu_glue_pkg::*; (
    input  logic     clk,
    input  logic     RESETn,
    input  cpu_bus_t main_bus,
    input  cpu_bus_t sub_bus,
    input  logic     vbl,
    input  logic     mbox_main_n,                 // Main CPU C700 select
    input  logic     mbox_sub_n,                  // Sub CPU C000 select
    output logic     main_int_n,
    output logic     sub_int_n,
    output logic     main_nmi_n,
    output logic     sub_nmi_n
);

    logic vbl_d;
    logic vbl_rise;

    // Mailbox terms, active low
    logic main_rd_n, main_wr_n;
    logic sub_rd_n, sub_wr_n;
    logic main_rd_d, sub_rd_d;
    logic main_rd_end, sub_rd_end;

    assign vbl_rise = vbl && !vbl_d;

    assign main_rd_n = mbox_main_n | main_bus.rd_n;
    assign main_wr_n = mbox_main_n | main_bus.wr_n;
    assign sub_rd_n  = mbox_sub_n  | sub_bus.rd_n;
    assign sub_wr_n  = mbox_sub_n  | sub_bus.wr_n;

    // Trigger on the trailing edge of the read
    assign main_rd_end = main_rd_n && !main_rd_d;
    assign sub_rd_end  = sub_rd_n  && !sub_rd_d;

    //----------------------------------------
    // Interrupt and NMI flip-flops
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            vbl_d      <= 1'b1;                   // No edge right out of reset
            main_rd_d  <= 1'b1;
            sub_rd_d   <= 1'b1;
            main_int_n <= 1'b1;
            sub_int_n  <= 1'b1;
            main_nmi_n <= 1'b1;
            sub_nmi_n  <= 1'b1;
        end else begin
            vbl_d     <= vbl;
            main_rd_d <= main_rd_n;
            sub_rd_d  <= sub_rd_n;

            // I/O cycle acknowledges the interrupt
            if (!main_bus.iorq_n) begin
                main_int_n <= 1'b1;
            end else if (vbl_rise) begin
                main_int_n <= 1'b0;
            end
            if (!sub_bus.iorq_n) begin
                sub_int_n <= 1'b1;
            end else if (vbl_rise) begin
                sub_int_n <= 1'b0;
            end

            // Own write clears, other side's read sets
            if (!main_wr_n) begin
                main_nmi_n <= 1'b1;
            end else if (sub_rd_end) begin
                main_nmi_n <= 1'b0;
            end
            if (!sub_wr_n) begin
                sub_nmi_n <= 1'b1;
            end else if (main_rd_end) begin
                sub_nmi_n <= 1'b0;
            end
        end
    end

endmodule

// File: main_cpu_decode.sv
//----------------------------------------
// Main CPU address decode
// I/O port strobes, AE and registered read data
//----------------------------------------
`timescale 1ns/10ps

module main_cpu_decode import cpu_glue_pkg::*; #(
    parameter logic [DATA_W-1:0] IDLE_DATA = 8'hFF
) (
    input  logic              clk,
    input  logic              RESETn,
    input  cpu_bus_t          bus,
    input  player_in_t        player1,
    input  player_in_t        player2,
    input  logic [15:0]       dsw,
    input  logic              snd_busy,
    input  logic [DATA_W-1:0] vlatch,
    output io_strobe_t        io_sel,
    output logic              page_n,
    output logic              vrd,
    output logic              ae,
    output logic [DATA_W-1:0] din
);

    logic page_io;
    logic io_en;

    // Player byte {1, missile, shot, armor, right, left, down, up}
    function automatic logic [DATA_W-1:0] player_byte(input player_in_t p);
        return {1'b1, p.missile, p.shot, p.armor, p.right, p.left, p.down, p.up};
    endfunction

    assign page_io = (bus.addr.io.page == PAGE_IO);
    assign io_en   = page_io && (bus.addr.io.region == REGION_IO) && !bus.mreq_n;

    // Page 3 outside the I/O region, address only
    assign page_n = !(page_io && (bus.addr.io.region != REGION_IO));
    assign ae     = !page_n && !bus.mreq_n;
    assign vrd    = ae && !bus.rd_n;              // Read of video area

    //----------------------------------------
    // Port strobes C000-C700
    //----------------------------------------
    always_comb begin
        io_sel = '1;
        if (io_en) begin
            case (bus.addr.io.port)
                3'd0:           io_sel.coin    = 1'b0;
                3'd1:           io_sel.p1      = 1'b0;
                3'd2:           io_sel.p2      = 1'b0;
                3'd3:           io_sel.p1_p2   = 1'b0;  // Unused port
                3'd4:           io_sel.mcode   = 1'b0;  // Write only
                3'd5:           io_sel.dip1    = 1'b0;
                3'd6:           io_sel.dip2    = 1'b0;
                PORT_MAILBOX_A: io_sel.mailbox = 1'b0;  // NMI trigger for sub CPU
                default:        io_sel         = '1;
            endcase
        end
    end

    //----------------------------------------
    // Read data mux, one clock behind the bus
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            din <= IDLE_DATA;
        end else if (!io_sel.coin) begin
            din <= {2'b11, snd_busy, player2.start, player1.start,
                    player1.service & player2.service, 1'b1,
                    player1.coin & player2.coin};
        end else if (!io_sel.p1) begin
            din <= player_byte(player1);
        end else if (!io_sel.p2) begin
            din <= player_byte(player2);
        end else if (!io_sel.dip1) begin
            din <= dsw[7:0];
        end else if (!io_sel.dip2) begin
            din <= dsw[15:8];
        end else if (vrd) begin
            din <= vlatch;                        // Latched video bus
        end else begin
            din <= IDLE_DATA;                     // ROM, mailbox, unmapped
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the glue logic testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_glue \
    -f tb.f -o sim_cpu_glue
./obj_dir/sim_cpu_glue > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
grep -q "Test completed successfully" sim.log

// File: sub_cpu_decode.sv
//----------------------------------------
// Sub CPU address decode
// Mailbox select, BE and registered read data
//----------------------------------------
`timescale 1ns/10ps

module sub_cpu_decode import cpu_glue_pkg::*; #(
    parameter logic [DATA_W-1:0] IDLE_DATA = 8'hFF
) (
    input  logic              clk,
    input  logic              RESETn,
    input  cpu_bus_t          bus,
    input  logic [DATA_W-1:0] vlatch,
    output logic              mbox_sel_n,
    output logic              page_n,
    output logic              vrd,
    output logic              be,
    output logic [DATA_W-1:0] din
);

    logic page_io;

    assign page_io = (bus.addr.io.page == PAGE_IO);

    // Mailbox at C000 only
    assign mbox_sel_n = !(page_io && (bus.addr.io.region == REGION_IO) &&
                          (bus.addr.io.port == PORT_MAILBOX_B) && !bus.mreq_n);

    // Same region rule as the main CPU
    assign page_n = !(page_io && (bus.addr.io.region != REGION_IO));
    assign be     = !page_n && !bus.mreq_n;
    assign vrd    = be && !bus.rd_n;

    // Mailbox read falls through to idle data
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            din <= IDLE_DATA;
        end else if (vrd) begin
            din <= vlatch;
        end else begin
            din <= IDLE_DATA;
        end
    end

endmodule

// File: tb.f
cpu_glue_pkg.sv
main_cpu_decode.sv
sub_cpu_decode.sv
cpu_irq_ctrl.sv
video_bus_ctrl.sv
cpu_glue_top.sv
cpu_glue_chk.sv
tb_clk_gen.sv
tb_cpu_glue.sv

// File: tb_clk_gen.sv
//----------------------------------------
// Testbench clock and reset generator
//----------------------------------------
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter realtime PERIOD     = 40ns,
    parameter int      RST_CYCLES = 2
) (
    output logic clk,
    output logic RESETn
);

    initial begin
        clk    = 1'b0;
        RESETn = 1'b0;                          // Held low from time zero
        repeat (RST_CYCLES) @(posedge clk);
        #2 RESETn = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tb_cpu_glue.sv
//----------------------------------------
// Glue logic testbench, bus cycles read
// from the input file and checked by rule
//----------------------------------------
`timescale 1ns/10ps

module tb_cpu_glue import cpu_glue_pkg::*;;

    logic clk, RESETn;
    cpu_bus_t main_bus, sub_bus;
    player_in_t player1, player2;
    logic [15:0] dsw;
    logic snd_busy, vbl, a_b, vdg_n, wba_n, wbb_n, rla, rlb;
    logic [7:0] v_in, main_din, sub_din, v_out;
    logic main_int_n, sub_int_n, main_nmi_n, sub_nmi_n, ae, be;
    io_strobe_t io_sel;
    logic [11:0] va;
    video_cs_t vcs;
    video_reg_t vreg;

    // Stimulus table
    logic [15:0] f_op[$], f_cpu[$], f_addr[$], f_data[$], f_aux[$], f_exp[$];
    int errors, checks, cycles, limit;
    logic [31:0] lfsr;
    logic main_int_m, sub_int_m, main_nmi_m, sub_nmi_m;   // Reference model state

    // Values caught during a cycle
    logic [7:0] c_din;
    io_strobe_t c_io;
    logic [11:0] c_va;
    video_cs_t c_vcs;
    video_reg_t c_vreg;
    logic c_ae, c_be;

    tb_clk_gen #(.PERIOD(40ns), .RST_CYCLES(2)) u_clk_gen (.clk(clk), .RESETn(RESETn));

    cpu_glue_top #(.IDLE_DATA(8'hFF)) u_cpu_glue_top (.*);

    //----------------------------------------
    // Helpers
    //----------------------------------------
    function automatic cpu_bus_t idle_bus();
        return '{addr: '0, dout: 8'hFF, mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32,22,2,1
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Active-low select byte, index 0 in bit 7
    function automatic logic [7:0] one_cold(input logic [2:0] idx);
        return ~(8'h80 >> idx);
    endfunction

    // Controls as a port byte, up in bit 0
    function automatic logic [7:0] pack_controls(input player_in_t p);
        return {1'b1, p.missile, p.shot, p.armor, p.right, p.left, p.down, p.up};
    endfunction

    // Hold one bus cycle 3 clocks, catch outputs, then go idle
    task automatic run_cycle(input logic cpu, input logic [15:0] addr,
                             input logic [7:0] dout, input int kind);
        cpu_bus_t b;
        b = idle_bus();
        b.addr = addr;
        b.dout = dout;
        if (kind == 2) b.iorq_n = 1'b0;
        else b.mreq_n = 1'b0;
        if (kind == 0) b.rd_n = 1'b0;
        if (kind == 1) b.wr_n = 1'b0;
        @(posedge clk);
        #2;
        if (cpu) sub_bus = b;
        else main_bus = b;
        @(negedge clk);                         // Combinational outputs settled
        c_io   = io_sel;
        c_va   = va;
        c_vcs  = vcs;
        c_vreg = vreg;
        c_ae   = ae;
        c_be   = be;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);                         // Two edges after apply
        c_din = cpu ? sub_din : main_din;
        @(posedge clk);
        #2;
        main_bus = idle_bus();
        sub_bus  = idle_bus();
        // Mailbox model, set on the read, cleared on own write
        if (addr == 16'hC700 && !cpu && kind == 0) sub_nmi_m = 1'b0;
        if (addr == 16'hC000 && cpu && kind == 1)  sub_nmi_m = 1'b1;
        if (addr == 16'hC000 && cpu && kind == 0)  main_nmi_m = 1'b0;
        if (addr == 16'hC700 && !cpu && kind == 1) main_nmi_m = 1'b1;
        if (kind == 2 && !cpu) main_int_m = 1'b1;
        if (kind == 2 && cpu)  sub_int_m = 1'b1;
        @(posedge clk);                         // NMI one clock after rd_n rises
        @(negedge clk);
        check_eq("main_nmi_n", main_nmi_n, main_nmi_m);
        check_eq("sub_nmi_n", sub_nmi_n, sub_nmi_m);
        check_eq("main_int_n", main_int_n, main_int_m);
        check_eq("sub_int_n", sub_int_n, sub_int_m);
    endtask

    // Plain read, din from the table, port strobe from the address
    task automatic bus_read(input logic cpu, input logic [15:0] addr, input logic [7:0] exp);
        logic [7:0] exp_io;
        exp_io = 8'hFF;
        if (!cpu && addr[15:11] == 5'b11000) begin
            exp_io = one_cold(addr[10:8]);      // Main CPU I/O page
        end
        run_cycle(cpu, addr, 8'hFF, 0);
        check_eq("din", c_din, exp);
        check_eq("io_sel", c_io, exp_io);
    endtask

    // Port read with fresh random controls
    task automatic port_read(input logic [15:0] addr);
        logic [31:0] r;
        logic [7:0] exp;
        @(posedge clk);
        #2;
        draw_bits(10, r);
        player1 = r[9:0];
        draw_bits(10, r);
        player2 = r[9:0];
        draw_bits(16, r);
        dsw = r[15:0];
        draw_bits(1, r);
        snd_busy = r[0];
        case (addr[10:8])
            3'd0: exp = {2'b11, snd_busy, player2.start, player1.start,
                         player1.service & player2.service, 1'b1, player1.coin & player2.coin};
            3'd1: exp = pack_controls(player1);
            3'd2: exp = pack_controls(player2);
            3'd5: exp = dsw[7:0];
            3'd6: exp = dsw[15:8];
            default: exp = 8'hFF;
        endcase
        run_cycle(1'b0, addr, 8'hFF, 0);
        check_eq("port din", c_din, exp);
        check_eq("io_sel", c_io, one_cold(addr[10:8]));
    endtask

    // Video area access, expectations from the region rule
    task automatic video_access(input logic cpu, input logic [15:0] addr, input logic [1:0] aux);
        logic [15:0] sa;
        logic hit;
        video_cs_t ecs;
        @(posedge clk);
        #2;
        a_b = aux[0];
        vdg_n = aux[1];
        sa = (a_b == cpu) ? addr : 16'h0000;
        hit = (sa[15:14] == 2'd3) && (sa[13:11] != 3'd0) && (a_b == cpu);
        ecs = '{front_cs_n: 1'b1, side_cs_n: 1'b1, back1_cs_n: 1'b1, disc: 1'b0, vrd_n: !hit};
        if (hit && sa[13:11] == 3'd1) ecs.disc = 1'b1;
        if (hit && sa[13:12] == 2'b01) ecs.front_cs_n = 1'b0;
        if (hit && sa[13:12] == 2'b10) ecs.back1_cs_n = 1'b0;
        if (hit && sa[13:12] == 2'b11) ecs.side_cs_n = 1'b0;
        run_cycle(cpu, addr, 8'hFF, 0);
        check_eq("va", c_va, sa[11:0]);
        check_eq("vcs", c_vcs, ecs);
        check_eq("vreg", c_vreg, (ecs.disc && !vdg_n) ? one_cold(sa[10:8]) : 8'hFF);
        check_eq("ae", c_ae, !cpu && addr[15:14] == 2'd3 && addr[13:11] != 3'd0);
        check_eq("be", c_be, cpu && addr[15:14] == 2'd3 && addr[13:11] != 3'd0);
        @(posedge clk);
        #2;
        a_b = 1'b0;
        vdg_n = 1'b1;
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        int fd, n;
        string line;
        logic [15:0] op, cpu, addr, data, aux, exp;
        $timeformat(-9, 0, " ns", 0);
        main_bus = idle_bus();
        sub_bus = idle_bus();
        player1 = '0;
        player2 = '0;
        dsw = '0;
        snd_busy = 1'b0;
        vbl = 1'b0;
        a_b = 1'b0;
        vdg_n = 1'b1;
        wba_n = 1'b1;
        wbb_n = 1'b1;
        rla = 1'b0;
        rlb = 1'b0;
        v_in = '0;
        errors = 0;
        checks = 0;
        limit = 0;
        lfsr = 32'h3e2f;
        main_int_m = 1'b1;
        sub_int_m = 1'b1;
        main_nmi_m = 1'b1;
        sub_nmi_m = 1'b1;
        fd = $fopen("cpu_glue_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file cpu_glue_input.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line, "%h %h %h %h %h %h", op, cpu, addr, data, aux, exp);
                if (n == 6) begin                // Comment and blank lines skipped
                    f_op.push_back(op);
                    f_cpu.push_back(cpu);
                    f_addr.push_back(addr);
                    f_data.push_back(data);
                    f_aux.push_back(aux);
                    f_exp.push_back(exp);
                end
            end
            $fclose(fd);
        end
        limit = 40 * f_op.size() + 100;
        wait (RESETn);
        foreach (f_op[i]) begin
            case (f_op[i])
                1: port_read(f_addr[i]);
                2: bus_read(f_cpu[i][0], f_addr[i], f_exp[i][7:0]);
                3: begin                         // Vertical blank edge
                    @(posedge clk);
                    #2;
                    vbl = 1'b1;
                    main_int_m = 1'b0;
                    sub_int_m = 1'b0;
                    @(posedge clk);              // Low one clock after the edge
                    @(negedge clk);
                    check_eq("main_int_n after vbl", main_int_n, 1'b0);
                    check_eq("sub_int_n after vbl", sub_int_n, 1'b0);
                    @(posedge clk);
                    #2;
                    vbl = 1'b0;
                end
                4: run_cycle(f_cpu[i][0], f_addr[i], 8'hFF, 2);
                5: run_cycle(f_cpu[i][0], f_addr[i], f_data[i][7:0], 1);
                6: video_access(f_cpu[i][0], f_addr[i], f_aux[i][1:0]);
                7: begin                         // Outgoing video word
                    @(posedge clk);
                    #2;
                    main_bus.dout = f_data[i][7:0];
                    sub_bus.dout = f_exp[i][7:0];
                    {wbb_n, wba_n} = f_aux[i][1:0];
                    @(negedge clk);
                    check_eq("v_out", v_out, !wba_n ? f_data[i][7:0] :
                                             !wbb_n ? f_exp[i][7:0] : 8'hFF);
                    @(posedge clk);
                    #2;
                    wba_n = 1'b1;
                    wbb_n = 1'b1;
                    main_bus = idle_bus();
                    sub_bus = idle_bus();
                end
                8: begin                         // Latch v_in for one CPU
                    @(posedge clk);
                    #2;
                    v_in = f_data[i][7:0];
                    if (f_cpu[i][0]) rlb = 1'b1;
                    else rla = 1'b1;
                    @(posedge clk);
                    #2;
                    rla = 1'b0;
                    rlb = 1'b0;
                    v_in = 8'h00;
                end
                default: begin
                    $display("Unknown operation code %0h in the stimulus file", f_op[i]);
                    errors++;
                end
            endcase
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run passed its limit of %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

// File: video_bus_ctrl.sv
//----------------------------------------
// Shared video bus control
// Address mux, chip selects, register strobes and read latches
//----------------------------------------
`timescale 1ns/10ps

module video_bus_ctrl import cpu_glue_pkg::*; (
    input  logic              clk,
    input  logic              RESETn,
    input  cpu_bus_t          main_bus,
    input  cpu_bus_t          sub_bus,
    input  logic              a_b,                // 0 main, 1 sub
    input  logic              main_page_n,
    input  logic              sub_page_n,
    input  logic              main_vrd,
    input  logic              sub_vrd,
    input  logic              vdg_n,              // Register strobe gate
    input  logic              wba_n,
    input  logic              wbb_n,
    input  logic              rla,
    input  logic              rlb,
    input  logic [DATA_W-1:0] v_in,
    output logic [VA_W-1:0]   va,
    output video_cs_t         vcs,
    output video_reg_t        vreg,
    output logic [DATA_W-1:0] v_out,
    output logic [DATA_W-1:0] main_vlatch,
    output logic [DATA_W-1:0] sub_vlatch
);

    cpu_bus_t   sel_bus;
    logic       sel_page_n;
    logic       sel_vrd;
    logic       vaccess;
    logic [2:0] region;
    logic       reg_en;

    //----------------------------------------
    // Bus owner select
    //----------------------------------------
    assign sel_bus    = a_b ? sub_bus     : main_bus;
    assign sel_page_n = a_b ? sub_page_n  : main_page_n;
    assign sel_vrd    = a_b ? sub_vrd     : main_vrd;

    assign va      = sel_bus.addr.mem.offset[VA_W-1:0];
    assign region  = sel_bus.addr.io.region;
    assign vaccess = !sel_page_n && !sel_bus.mreq_n;   // Page 3, not I/O

    // Region pairs share a select
    always_comb begin
        vcs            = '{front_cs_n: 1'b1, side_cs_n: 1'b1, back1_cs_n: 1'b1,
                           disc: 1'b0, vrd_n: 1'b1};
        vcs.vrd_n      = !sel_vrd;
        if (vaccess) begin
            case (region[2:1])
                2'b01:   vcs.front_cs_n = 1'b0;   // D000-DFFF
                2'b10:   vcs.back1_cs_n = 1'b0;   // E000-EFFF
                2'b11:   vcs.side_cs_n  = 1'b0;   // F000-FFFF
                default: vcs.disc       = (region == REGION_VREG);
            endcase
        end
    end

    //----------------------------------------
    // Register strobes C800-CF00
    //----------------------------------------
    assign reg_en = vcs.disc && !vdg_n;

    always_comb begin
        vreg = '1;
        if (reg_en) begin
            case (va[10:8])
                3'd0:    vreg.msb        = 1'b0;  // Video attributes
                3'd1:    vreg.fsx        = 1'b0;  // Front scroll X
                3'd2:    vreg.fsy        = 1'b0;
                3'd3:    vreg.b1sx       = 1'b0;  // Back1 scroll X
                3'd4:    vreg.b1sy       = 1'b0;
                3'd5:    vreg.spare      = 1'b0;
                3'd6:    vreg.side_bank  = 1'b0;
                default: vreg.back1_bank = 1'b0;
            endcase
        end
    end

    // Main CPU has priority on the outgoing word
    assign v_out = !wba_n ? main_bus.dout :
                   !wbb_n ? sub_bus.dout  : 8'hFF;

    // Read latches, held while rla/rlb low
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            main_vlatch <= '0;
            sub_vlatch  <= '0;
        end else begin
            if (rla) begin
                main_vlatch <= v_in;
            end
            if (rlb) begin
                sub_vlatch <= v_in;
            end
        end
    end

endmodule
